//--- src/j4io_pkg.sv
package j4io_pkg;

  // word and address widths
  localparam int data_w    = 16;  // i/o word
  localparam int slot_w    = 2;   // four processor slots
  localparam int sel_w     = 16;  // one-hot register selects
  localparam int sample_aw = 8;   // 256-word sample memory
  localparam int addr_w    = 20;  // axi byte address, select in 17..2, slot in 19..18

  // one-hot register map, bit index into the select field
  localparam int reg_gpio       = 0;   // r: pins in, w: output latch
  localparam int reg_gpio_dir   = 1;   // r/w: direction, 1 drives the pin
  localparam int reg_task1      = 8;   // task word for slot 1
  localparam int reg_task2      = 9;
  localparam int reg_task3      = 10;
  localparam int reg_sample     = 11;  // sample memory data port
  localparam int reg_ctrl       = 13;  // pointer presets, status on read
  localparam int reg_task_fetch = 14;  // r: own task, w: kill request
  localparam int reg_ticks_mask = 15;  // r: wall clock, w: mask for next access

  // control word written to reg_ctrl
  localparam int ctrl_set_wr = 11;  // load the write pointer from bits 7..0
  localparam int ctrl_set_rd = 10;  // load the read pointer from bits 7..0

  // masks and read words share one type
  typedef logic [data_w-1:0] io_mask_t;

  // one registered access as seen by the data blocks
  typedef struct packed {
    logic              rd;     // one-cycle read strobe
    logic              wr;     // one-cycle write strobe
    logic [sel_w-1:0]  sel;    // one-hot register select
    logic [slot_w-1:0] slot;   // issuing slot
    logic [data_w-1:0] wdata;  // write payload
  } io_req_t;

endpackage

//--- src/io_access_ctrl.sv
`timescale 1ns/1ps

module io_access_ctrl import j4io_pkg::*; #(
  parameter int data_w = j4io_pkg::data_w
) (
  input  logic              clk,
  input  logic              resetq,
  // write address / data / response
  input  logic [addr_w-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [data_w-1:0] wdata,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  // read address / data
  input  logic [addr_w-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  // read words back from the data blocks, already gated by their selects
  input  io_mask_t          gpio_rd,
  input  io_mask_t          task_rd,
  input  io_mask_t          tick_rd,
  input  io_mask_t          sample_rd,
  output io_mask_t          mask,     // current mask of the issuing slot
  output io_req_t           io_req
);

  typedef enum logic [1:0] {st_idle, st_access, st_respond} state_t;

  state_t            state;
  logic              is_rd;           // current access is a read
  logic              req_rd, req_wr;  // one-cycle strobes
  logic [sel_w-1:0]  req_sel;
  logic [slot_w-1:0] req_slot;
  logic [data_w-1:0] req_wdata;
  io_mask_t          mask_preset [4]; // one per slot
  io_mask_t          rd_acc;          // captured combinational read words
  io_mask_t          rd_mask;         // mask in force for that read
  logic              take_rd, take_wr;
  logic [addr_w-1:0] addr;

  assign awready = (state == st_idle) && !arvalid;  // a pending read goes first
  assign wready  = (state == st_idle) && !arvalid;
  assign arready = (state == st_idle);

  assign take_rd = (state == st_idle) && arvalid;               // read wins a tie
  assign take_wr = (state == st_idle) && !arvalid && awvalid && wvalid;
  assign addr    = arvalid ? araddr : awaddr;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      state  <= st_idle;
      is_rd  <= 1'b0;
      req_rd <= 1'b0;
      req_wr <= 1'b0;
    end else begin
      req_rd <= take_rd;
      req_wr <= take_wr;
      case (state)
        st_idle: if (take_rd || take_wr) begin
          state <= st_access;
          is_rd <= take_rd;
        end
        st_access: state <= st_respond;  // data blocks act this cycle
        st_respond: if (is_rd ? rready : bready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // access payload, only loaded when an access is taken
  always_ff @(posedge clk) begin
    if (take_rd || take_wr) begin
      req_sel   <= addr[sel_w+1:2];
      req_slot  <= addr[sel_w+slot_w+1:sel_w+2];
      req_wdata <= wdata;
    end
  end

  // a mask write arms the slot's mask, any other access restores all ones
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < 4; i++) mask_preset[i] <= '1;
    end else if (req_rd || req_wr) begin
      mask_preset[req_slot] <= (req_wr && req_sel[reg_ticks_mask]) ? req_wdata : '1;
    end
  end

  assign mask = mask_preset[req_slot];

  // sample word arrives a cycle late, so only the others are caught here
  always_ff @(posedge clk) begin
    if (req_rd) begin
      rd_acc  <= gpio_rd | task_rd | tick_rd;
      rd_mask <= mask;
    end
  end

  assign rdata  = (rd_acc | sample_rd) & rd_mask;
  assign rvalid = (state == st_respond) && is_rd;
  assign bvalid = (state == st_respond) && !is_rd;
  assign rresp  = 2'b00;  // always okay
  assign bresp  = 2'b00;

  assign io_req = '{rd: req_rd, wr: req_wr, sel: req_sel, slot: req_slot, wdata: req_wdata};

endmodule

//--- src/io_timers.sv
`timescale 1ns/1ps

module io_timers import j4io_pkg::*; #(
  parameter int data_w    = j4io_pkg::data_w,
  parameter int sample_aw = j4io_pkg::sample_aw
) (
  input  logic                 clk,
  input  logic                 resetq,
  input  io_req_t              io_req,
  output io_mask_t             tick_rd,
  output logic [sample_aw-1:0] sample_raddr,
  output logic [sample_aw-1:0] sample_waddr
);

  logic [data_w-1:0] ticks;  // wall clock, wraps
  logic              set_wr, set_rd, smp_wr, smp_rd;

  assign set_wr = io_req.wr && io_req.sel[reg_ctrl] && io_req.wdata[ctrl_set_wr];
  assign set_rd = io_req.wr && io_req.sel[reg_ctrl] && io_req.wdata[ctrl_set_rd];
  assign smp_wr = io_req.wr && io_req.sel[reg_sample];  // pointer steps after use
  assign smp_rd = io_req.rd && io_req.sel[reg_sample];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      ticks        <= '0;
      sample_raddr <= '0;
      sample_waddr <= '0;
    end else begin
      ticks <= ticks + 1'b1;
      if (set_wr) sample_waddr <= io_req.wdata[sample_aw-1:0];  // preset wins
      else if (smp_wr) sample_waddr <= sample_waddr + 1'b1;
      if (set_rd) sample_raddr <= io_req.wdata[sample_aw-1:0];
      else if (smp_rd) sample_raddr <= sample_raddr + 1'b1;
    end
  end

  // msb of the status word tells a worker slot from slot 0
  assign tick_rd = (io_req.sel[reg_ticks_mask] ? ticks : '0) |
                   (io_req.sel[reg_ctrl] ? {(io_req.slot != '0), {(data_w-1){1'b0}}} : '0);

endmodule

//--- src/gpio_port.sv
`timescale 1ns/1ps

module gpio_port import j4io_pkg::*; #(
  parameter int data_w = j4io_pkg::data_w
) (
  input  logic              clk,
  input  logic              resetq,
  input  io_req_t           io_req,
  input  io_mask_t          mask,      // bits allowed to change
  input  logic [data_w-1:0] gpio_in,
  output logic [data_w-1:0] gpio_out,
  output logic [data_w-1:0] gpio_oe,   // 1 drives the pin
  output io_mask_t          gpio_rd
);

  logic [data_w-1:0] out_q;
  logic [data_w-1:0] dir_q;

  // keep unmasked bits, take masked bits from the write
  function automatic logic [data_w-1:0] merge(input logic [data_w-1:0] old_v,
                                              input logic [data_w-1:0] new_v,
                                              input logic [data_w-1:0] m);
    return (old_v & ~m) | (new_v & m);
  endfunction

  always_ff @(posedge clk) begin
    if (!resetq) begin
      out_q <= '0;
      dir_q <= '0;  // all pins start as inputs
    end else if (io_req.wr) begin
      if (io_req.sel[reg_gpio])
        out_q <= merge(out_q, io_req.wdata, mask);
      if (io_req.sel[reg_gpio_dir])
        dir_q <= merge(dir_q, io_req.wdata, mask);  // threads can share the port this way
    end
  end

  assign gpio_out = out_q;
  assign gpio_oe  = dir_q;

  // pins read back, not the latch
  assign gpio_rd = (io_req.sel[reg_gpio]     ? gpio_in : '0) |
                   (io_req.sel[reg_gpio_dir] ? dir_q   : '0);

endmodule

//--- src/task_slots.sv
`timescale 1ns/1ps

module task_slots import j4io_pkg::*; #(
  parameter int data_w = j4io_pkg::data_w
) (
  input  logic     clk,
  input  logic     resetq,
  input  io_req_t  io_req,
  output io_mask_t task_rd,
  output logic [3:0] kill_slot  // one-cycle reset request per slot
);

  logic [data_w-1:0] task_q [1:3];  // task xt for slots 1..3
  logic [data_w-1:0] fetch_w;       // word seen by the issuing slot
  logic              fetch;
  io_mask_t          list_rd;

  assign fetch = io_req.rd && io_req.sel[reg_task_fetch];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 1; i <= 3; i++) task_q[i] <= '0;  // stops every worker
      kill_slot <= '0;
    end else begin
      kill_slot <= (io_req.wr && io_req.sel[reg_task_fetch]) ? io_req.wdata[3:0] : 4'b0;
      for (int i = 1; i <= 3; i++) begin
        if (io_req.wr && io_req.sel[reg_task1+i-1])
          task_q[i] <= io_req.wdata;       // any slot may assign any task
        else if (fetch && io_req.slot == i && task_q[i][0])
          task_q[i] <= '0;                 // run-once task, gone after one fetch
      end
    end
  end

  // valid xts are even, bit 0 only flags run-once
  always_comb begin
    case (io_req.slot)
      2'd1:    fetch_w = {task_q[1][data_w-1:1], 1'b0};
      2'd2:    fetch_w = {task_q[2][data_w-1:1], 1'b0};
      2'd3:    fetch_w = {task_q[3][data_w-1:1], 1'b0};
      default: fetch_w = '0;  // slot 0 never gets a task
    endcase
  end

  always_comb begin
    list_rd = '0;
    for (int i = 1; i <= 3; i++)
      if (io_req.sel[reg_task1+i-1]) list_rd = list_rd | task_q[i];
  end

  assign task_rd = list_rd | (io_req.sel[reg_task_fetch] ? fetch_w : '0);

endmodule

//--- src/sample_ram.sv
`timescale 1ns/1ps

module sample_ram import j4io_pkg::*; #(
  parameter int data_w    = j4io_pkg::data_w,
  parameter int sample_aw = j4io_pkg::sample_aw
) (
  input  logic                 clk,
  input  io_req_t              io_req,
  input  logic [sample_aw-1:0] sample_raddr,
  input  logic [sample_aw-1:0] sample_waddr,
  output io_mask_t             sample_rd
);

  logic [data_w-1:0] mem [2**sample_aw];

  always_ff @(posedge clk) begin
    if (io_req.wr && io_req.sel[reg_sample])
      mem[sample_waddr] <= io_req.wdata;  // pointer steps on the same edge
  end

  // word stays put until the next read, so a stalled response holds
  always_ff @(posedge clk) begin
    if (io_req.rd)
      sample_rd <= io_req.sel[reg_sample] ? mem[sample_raddr] : '0;
  end

endmodule

//--- src/io_top.sv
`timescale 1ns/1ps

module io_top import j4io_pkg::*; #(
  parameter int data_w    = j4io_pkg::data_w,
  parameter int sample_aw = j4io_pkg::sample_aw
) (
  input  logic              clk,
  input  logic              resetq,
  input  logic [addr_w-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [data_w-1:0] wdata,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [addr_w-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  output logic [data_w-1:0] gpio_out,
  output logic [data_w-1:0] gpio_oe,
  input  logic [data_w-1:0] gpio_in,
  output logic [3:0]        kill_slot
);

  io_req_t              io_req;
  io_mask_t             mask;
  io_mask_t             gpio_rd, task_rd, tick_rd, sample_rd;
  logic [sample_aw-1:0] sample_raddr, sample_waddr;

  io_access_ctrl #(.data_w(data_w)) ctrl_i (
    .clk, .resetq,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .gpio_rd, .task_rd, .tick_rd, .sample_rd,
    .mask, .io_req
  );

  gpio_port #(.data_w(data_w)) gpio_i (
    .clk, .resetq, .io_req, .mask, .gpio_in, .gpio_out, .gpio_oe, .gpio_rd
  );

  task_slots #(.data_w(data_w)) tasks_i (
    .clk, .resetq, .io_req, .task_rd, .kill_slot
  );

  io_timers #(.data_w(data_w), .sample_aw(sample_aw)) timers_i (
    .clk, .resetq, .io_req, .tick_rd, .sample_raddr, .sample_waddr
  );

  sample_ram #(.data_w(data_w), .sample_aw(sample_aw)) ram_i (
    .clk, .io_req, .sample_raddr, .sample_waddr, .sample_rd
  );

endmodule

//--- bench/io_top_properties.sv
`timescale 1ns/1ps

module io_top_properties import j4io_pkg::*; #(
  parameter int data_w = j4io_pkg::data_w
) (
  input logic              clk,
  input logic              resetq,
  input logic              awready,
  input logic              wready,
  input logic              arready,
  input logic              bvalid,
  input logic              bready,
  input logic [1:0]        bresp,
  input logic              rvalid,
  input logic              rready,
  input logic [1:0]        rresp,
  input logic [data_w-1:0] rdata,
  input logic [3:0]        kill_slot
);

  // responses hold until taken
  b_hold: assert property (@(posedge clk) disable iff (!resetq)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response changed before bready");

  r_hold: assert property (@(posedge clk) disable iff (!resetq)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response changed before rready");

  reset_state: assert property (@(posedge clk)
    !resetq |=> awready && wready && arready && !bvalid && !rvalid && kill_slot == 4'b0)
    else $error("bus or kill outputs not idle after reset");

  kill_pulse: assert property (@(posedge clk) disable iff (!resetq)
    kill_slot != 4'b0 |=> kill_slot == 4'b0)
    else $error("kill_slot held longer than one cycle");

endmodule

bind io_top io_top_properties #(.data_w(data_w)) props_i (
  .clk, .resetq, .awready, .wready, .arready, .bvalid, .bready, .bresp,
  .rvalid, .rready, .rresp, .rdata, .kill_slot
);

//--- bench/io_top_tb.sv
`timescale 1ns/1ps

module io_top_tb import j4io_pkg::*;;

  localparam int wait_limit = 100;  // cycles per handshake wait

  logic              clk = 1'b0;
  logic              resetq;
  logic [addr_w-1:0] awaddr, araddr;
  logic              awvalid, wvalid, bready, arvalid, rready;
  logic [data_w-1:0] wdata, gpio_in;
  logic              awready, wready, bvalid, arready, rvalid;
  logic [1:0]        bresp, rresp;
  logic [data_w-1:0] rdata, gpio_out, gpio_oe;
  logic [3:0]        kill_slot, kill_seen;
  int                kill_cycles = 0;
  int                errors = 0, tests = 0, failed_tests = 0, errors_before;
  logic [15:0]       lfsr = 16'd63156;
  logic [15:0]       m, v, g, t1, t2, dt, rd;
  logic [7:0]        base;
  logic [15:0]       words [8];

  io_top #(.data_w(data_w), .sample_aw(sample_aw)) dut_i (.*);

  always #5 clk = ~clk;

  // every nonzero kill word seen at a falling edge, with its length
  always @(negedge clk) begin
    if (resetq && kill_slot != 4'b0) begin
      kill_seen   <= kill_slot;
      kill_cycles <= kill_cycles + 1;
    end
  end

  // galois lfsr, one step per bit handed out
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [addr_w-1:0] addr_of(input logic [1:0] slot, input int sel);
    logic [sel_w-1:0] onehot;
    onehot      = '0;
    onehot[sel] = 1'b1;
    return {slot, onehot, 2'b00};
  endfunction

  task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
    assert (got === exp)
    else begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not arrive within %0d cycles", what, wait_limit);
    errors++;
  endtask

  task automatic axi_write(input logic [1:0] slot, input int sel, input logic [15:0] data);
    int n;
    @(posedge clk);
    awaddr  <= addr_of(slot, sel);
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(awready && wready) && n < wait_limit);
    if (!(awready && wready)) report_timeout("awready and wready");
    @(posedge clk);  // aw and w taken on this edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!bvalid && n < wait_limit);
    if (!bvalid) report_timeout("bvalid");
    check_eq(16'(bresp), 16'h0, "bresp");
    @(posedge clk);
    bready <= 1'b1;  // response waits a cycle first
    @(posedge clk);  // b taken here
    bready <= 1'b0;
  endtask

  // stall holds rready low for that many cycles once rvalid is up
  task automatic axi_read(input logic [1:0] slot, input int sel, input int stall,
                          output logic [15:0] data);
    int n;
    @(posedge clk);
    araddr  <= addr_of(slot, sel);
    arvalid <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < wait_limit);
    if (!arready) report_timeout("arready");
    @(posedge clk);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rvalid && n < wait_limit);
    if (!rvalid) report_timeout("rvalid");
    data = rdata;
    check_eq(16'(rresp), 16'h0, "rresp");
    repeat (stall) @(posedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);  // r taken here
    rready <= 1'b0;
  endtask

  task automatic test_done(input string name);
    tests++;
    if (errors != errors_before) failed_tests++;
    $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
    errors_before = errors;
  endtask

  initial begin
    resetq  = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    gpio_in = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    errors_before = 0;
    repeat (16) @(posedge clk);
    resetq <= 1'b1;

    m = rand_bits(16);
    v = rand_bits(16);
    axi_write(2'd1, reg_ticks_mask, m);
    axi_write(2'd1, reg_gpio_dir, v);
    check_eq(gpio_oe, v & m, "gpio_oe after masked write");  // register was 0
    v = rand_bits(16);
    axi_write(2'd1, reg_gpio_dir, v);
    check_eq(gpio_oe, v, "gpio_oe after unmasked write");
    m = rand_bits(16);
    v = rand_bits(16);
    axi_write(2'd1, reg_ticks_mask, m);
    axi_write(2'd1, reg_gpio, v);
    check_eq(gpio_out, v & m, "gpio_out after masked write");  // latch was 0
    test_done("masked gpio write");

    g = rand_bits(16);
    m = rand_bits(16);
    @(posedge clk);
    gpio_in <= g;
    axi_write(2'd2, reg_ticks_mask, m);
    axi_read(2'd3, reg_gpio, 0, rd);
    check_eq(rd, g, "slot 3 gpio read");  // slot 2 mask must not leak
    axi_read(2'd2, reg_gpio, 0, rd);
    check_eq(rd, g & m, "slot 2 masked gpio read");
    test_done("masked read");

    v = rand_bits(16) & 16'hfffe;
    axi_write(2'd0, reg_task2, v);
    axi_read(2'd2, reg_task_fetch, 0, rd);
    check_eq(rd, v, "task fetch");
    axi_write(2'd0, reg_task2, v | 16'h1);  // run-once
    axi_read(2'd2, reg_task_fetch, 0, rd);
    check_eq(rd, v, "run-once fetch");
    axi_read(2'd2, reg_task_fetch, 0, rd);
    check_eq(rd, 16'h0, "run-once word after fetch");
    for (int i = 0; i < 3; i++)
      axi_write(2'd0, reg_task1 + i, v);  // every worker slot has a task now
    axi_read(2'd0, reg_task_fetch, 0, rd);
    check_eq(rd, 16'h0, "slot 0 fetch");
    test_done("task fetch");

    check_eq(16'(kill_cycles), 16'h0, "kill pulses before kill write");
    v = rand_bits(4) | 16'h1;  // never zero
    axi_write(2'd0, reg_task_fetch, v);
    axi_read(2'd0, reg_ticks_mask, 0, rd);
    check_eq(16'(kill_seen), v, "kill_slot value");
    check_eq(16'(kill_cycles), 16'h1, "kill_slot pulse length");
    test_done("kill");

    base = 8'(rand_bits(8));
    axi_write(2'd0, reg_ctrl, 16'h0c00 | 16'(base));  // preset both pointers
    for (int i = 0; i < 8; i++) begin
      words[i] = rand_bits(16);
      axi_write(2'd0, reg_sample, words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      axi_read(2'd0, reg_sample, i % 3, rd);
      check_eq(rd, words[i], $sformatf("sample word %0d", i));
    end
    test_done("sample ram");

    axi_read(2'd0, reg_ticks_mask, 0, t1);
    axi_read(2'd0, reg_ticks_mask, 0, t2);
    dt = t2 - t1;
    assert (dt != 16'h0 && dt < 16'h0100)
    else begin
      $display("Fail at %0t ns: tick step %0d is not a small positive value", $time, dt);
      errors++;
    end
    axi_read(2'd0, reg_ctrl, 0, rd);
    check_eq(rd, 16'h0000, "status from slot 0");
    axi_read(2'd3, reg_ctrl, 0, rd);
    check_eq(rd, 16'h8000, "status from slot 3");
    test_done("wall clock and status");

    $display("summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- build.f
src/j4io_pkg.sv
src/io_access_ctrl.sv
src/io_timers.sv
src/gpio_port.sv
src/task_slots.sv
src/sample_ram.sv
src/io_top.sv
bench/io_top_properties.sv
bench/io_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= io_top_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
